// File: core_pkg.sv
package core_pkg;

	localparam int xlen = 32;

	// Memory operation carried by an execute bundle.
	typedef enum logic [3:0] {
		MEN_X   = 4'd0,
		MEN_SB  = 4'd1,
		MEN_SH  = 4'd2,
		MEN_SW  = 4'd3,
		MEN_LB  = 4'd4,
		MEN_LBU = 4'd5,
		MEN_LH  = 4'd6,
		MEN_LHU = 4'd7,
		MEN_LW  = 4'd8
	} mem_op_t;

	typedef enum logic [1:0] {
		MEMORY_CMD_NOP   = 2'd0,
		MEMORY_CMD_READ  = 2'd1,
		MEMORY_CMD_WRITE = 2'd2
	} mem_cmd_t;

	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC  = 2'd2
	} wb_sel_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] alu_out;
		logic            br_flg;
		logic [xlen-1:0] br_target;
		mem_op_t         mem_op;
		logic            rf_wen;
		wb_sel_t         wb_sel;
		logic [4:0]      wb_addr;
		logic            jmp_flg;
		logic            ecall;
	} ex_mem_t;

	// Same bundle after memory; the load result replaces the store data.
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] alu_out;
		logic            br_flg;
		logic [xlen-1:0] br_target;
		logic            rf_wen;
		wb_sel_t         wb_sel;
		logic [4:0]      wb_addr;
		logic            jmp_flg;
		logic            ecall;
		logic [xlen-1:0] read_data;
	} mem_wb_t;

endpackage

// File: data_ram.sv
`timescale 1ns/1ps

module data_ram #(
	parameter int DEPTH_WORDS  = 256,
	parameter int READ_LATENCY = 2
) (
	input logic clk,
	input logic arst_n,
	mem_bus_if.responder bus
);

	import core_pkg::*;

	typedef logic [$clog2(DEPTH_WORDS)-1:0] idx_t;
	typedef logic [$clog2(READ_LATENCY+1)-1:0] lat_t;

	logic [xlen-1:0] mem [DEPTH_WORDS];
	logic [xlen-1:0] rdata_q;
	idx_t            idx;
	lat_t            lat_cnt;
	logic            busy;
	logic            take;
	logic            take_read;
	logic            take_write;

	assign idx = bus.addr[$clog2(DEPTH_WORDS)+1:2];

	// No new command while a read is still on its way back.
	assign bus.cmd_ready = !busy;
	assign take = (bus.cmd != MEMORY_CMD_NOP) && bus.cmd_ready;
	assign take_read = take && (bus.cmd == MEMORY_CMD_READ);
	assign take_write = take && (bus.cmd == MEMORY_CMD_WRITE);

	assign bus.rdata = rdata_q;
	assign bus.rdata_valid = busy && (lat_cnt == lat_t'(1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			lat_cnt <= '0;
		end else if (take_read) begin
			busy <= 1'b1;
			lat_cnt <= lat_t'(READ_LATENCY);
		end else if (busy) begin
			lat_cnt <= lat_cnt - lat_t'(1);
			if (lat_cnt == lat_t'(1))
				busy <= 1'b0;
		end
	end

	// The word is sampled at the take; writes are blocked until it is returned.
	always_ff @(posedge clk) begin
		if (take_write) begin
			for (int b = 0; b < 4; b++) begin
				if (bus.wmask[b])
					mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
			end
		end
		if (take_read)
			rdata_q <= mem[idx];
	end

endmodule

// File: mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;

	import core_pkg::*;

	mem_cmd_t        cmd;
	logic            cmd_ready;
	logic [xlen-1:0] addr;
	logic [xlen-1:0] wdata;
	logic [3:0]      wmask;
	logic [xlen-1:0] rdata;
	logic            rdata_valid;

	modport requester (
		output cmd,
		input  cmd_ready,
		output addr,
		output wdata,
		output wmask,
		input  rdata,
		input  rdata_valid
	);

	// The RAM answers each read with a single rdata_valid pulse.
	modport responder (
		input  cmd,
		output cmd_ready,
		input  addr,
		input  wdata,
		input  wmask,
		output rdata,
		output rdata_valid
	);

endinterface

// File: mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top #(
	parameter int DEPTH_WORDS  = 256,
	parameter int READ_LATENCY = 2
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      in_valid,
	output logic                      in_ready,
	input  logic [core_pkg::xlen-1:0] in_pc,
	input  logic [core_pkg::xlen-1:0] in_rs2_data,
	input  logic [core_pkg::xlen-1:0] in_alu_out,
	input  logic [core_pkg::xlen-1:0] in_br_target,
	input  logic                      in_br_flg,
	input  logic                      in_rf_wen,
	input  logic                      in_jmp_flg,
	input  logic                      in_ecall,
	input  core_pkg::mem_op_t         in_mem_op,
	input  core_pkg::wb_sel_t         in_wb_sel,
	input  logic [4:0]                in_wb_addr,
	output logic                      out_valid,
	input  logic                      out_ready,
	output logic                      rd_wen,
	output logic [4:0]                rd_addr,
	output logic [core_pkg::xlen-1:0] rd_data,
	output logic                      redirect,
	output logic [core_pkg::xlen-1:0] redirect_pc,
	output logic                      ecall
);

	import core_pkg::*;

	stage_if #(.payload_t(ex_mem_t)) ex_if ();
	stage_if #(.payload_t(mem_wb_t)) wb_if ();
	mem_bus_if bus_if ();

	assign ex_if.valid = in_valid;
	assign in_ready = ex_if.ready;

	assign ex_if.payload.pc        = in_pc;
	assign ex_if.payload.rs2_data  = in_rs2_data;
	assign ex_if.payload.alu_out   = in_alu_out;
	assign ex_if.payload.br_flg    = in_br_flg;
	assign ex_if.payload.br_target = in_br_target;
	assign ex_if.payload.mem_op    = in_mem_op;
	assign ex_if.payload.rf_wen    = in_rf_wen;
	assign ex_if.payload.wb_sel    = in_wb_sel;
	assign ex_if.payload.wb_addr   = in_wb_addr;
	assign ex_if.payload.jmp_flg   = in_jmp_flg;
	assign ex_if.payload.ecall     = in_ecall;

	memory_stage u_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.up     (ex_if),
		.down   (wb_if),
		.bus    (bus_if)
	);

	data_ram #(
		.DEPTH_WORDS  (DEPTH_WORDS),
		.READ_LATENCY (READ_LATENCY)
	) u_ram (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (bus_if)
	);

	writeback_unit u_wb (
		.clk         (clk),
		.arst_n      (arst_n),
		.up          (wb_if),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.rd_wen      (rd_wen),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ecall       (ecall)
	);

endmodule

// File: memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
	input logic     clk,
	input logic     arst_n,
	stage_if.sink   up,
	stage_if.source down,
	mem_bus_if.requester bus
);

	import core_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT_READ,
		ST_DONE
	} state_t;

	state_t          state;
	ex_mem_t         saved;
	logic [xlen-1:0] load_data;
	logic            out_valid_q;
	mem_wb_t         out_q;
	logic            accept;
	logic            is_store;
	logic            cmd_taken;
	logic            fill_done;
	logic [1:0]      offset;

	function automatic mem_wb_t to_wb(ex_mem_t b, logic [xlen-1:0] rd);
		mem_wb_t w;
		w.pc        = b.pc;
		w.alu_out   = b.alu_out;
		w.br_flg    = b.br_flg;
		w.br_target = b.br_target;
		w.rf_wen    = b.rf_wen;
		w.wb_sel    = b.wb_sel;
		w.wb_addr   = b.wb_addr;
		w.jmp_flg   = b.jmp_flg;
		w.ecall     = b.ecall;
		w.read_data = rd;
		return w;
	endfunction

	// Pull the addressed lanes down to bit 0 and extend them.
	function automatic logic [xlen-1:0] load_extend(mem_op_t op, logic [xlen-1:0] word,
			logic [1:0] off);
		logic [xlen-1:0] lanes;
		lanes = word >> {off, 3'b000};
		case (op)
			MEN_LB:  return {{(xlen-8){lanes[7]}}, lanes[7:0]};
			MEN_LBU: return {{(xlen-8){1'b0}}, lanes[7:0]};
			MEN_LH:  return {{(xlen-16){lanes[15]}}, lanes[15:0]};
			MEN_LHU: return {{(xlen-16){1'b0}}, lanes[15:0]};
			default: return lanes;
		endcase
	endfunction

	assign up.ready = (state == ST_IDLE) && (!out_valid_q || down.ready);
	assign accept = up.valid && up.ready;

	assign is_store = saved.mem_op inside {MEN_SB, MEN_SH, MEN_SW};
	assign offset = saved.alu_out[1:0];

	assign bus.cmd = (state != ST_ISSUE) ? MEMORY_CMD_NOP :
		is_store ? MEMORY_CMD_WRITE : MEMORY_CMD_READ;
	assign bus.addr = saved.alu_out;
	assign bus.wdata = saved.rs2_data << {offset, 3'b000};
	assign cmd_taken = (state == ST_ISSUE) && bus.cmd_ready;

	always_comb begin
		case (saved.mem_op)
			MEN_SB:  bus.wmask = 4'b0001 << offset;
			MEN_SH:  bus.wmask = 4'b0011 << offset;
			default: bus.wmask = 4'b1111;
		endcase
	end

	assign fill_done = (state == ST_DONE) && (!out_valid_q || down.ready);

	assign down.valid = out_valid_q;
	assign down.payload = out_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			out_valid_q <= 1'b0;
		end else begin
			if (out_valid_q && down.ready)
				out_valid_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept && up.payload.mem_op == MEN_X)
						out_valid_q <= 1'b1;
					else if (accept)
						state <= ST_ISSUE;
				end
				ST_ISSUE: begin
					if (cmd_taken)
						state <= is_store ? ST_DONE : ST_WAIT_READ;
				end
				ST_WAIT_READ: begin
					if (bus.rdata_valid)
						state <= ST_DONE;
				end
				default: begin
					if (fill_done) begin
						out_valid_q <= 1'b1;
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			saved <= up.payload;
			load_data <= '1;
		end
		if (state == ST_WAIT_READ && bus.rdata_valid)
			load_data <= load_extend(saved.mem_op, bus.rdata, offset);
		if (accept && up.payload.mem_op == MEN_X)
			out_q <= to_wb(up.payload, '1);
		else if (fill_done)
			out_q <= to_wb(saved, load_data);
	end

endmodule

// File: project.f
core_pkg.sv
stage_if.sv
mem_bus_if.sv
memory_stage.sv
data_ram.sv
writeback_unit.sv
mem_wb_top.sv
tb_clock.sv
tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and decides pass or fail from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f project.f -o tb_top \
	&& ./obj_dir/tb_top > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete."; exit 1; }
cat sim.log
grep -q "^TEST PASSED$" sim.log && echo "Log check ok." || { echo "Log check failed."; exit 1; }

// File: stage_if.sv
`timescale 1ns/1ps

interface stage_if #(
	parameter type payload_t = logic
);

	logic     valid;
	logic     ready;
	payload_t payload;

	// Transfer on a rising edge with valid and ready both high.
	modport source (
		output valid,
		output payload,
		input  ready
	);

	modport sink (
		input  valid,
		input  payload,
		output ready
	);

endinterface

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset is released shortly after the third rising edge.
	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		#2 arst_n = 1'b1;
	end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

	import core_pkg::*;

	typedef struct packed {
		logic        rd_wen;
		logic [4:0]  rd_addr;
		logic [31:0] rd_data;
		logic        redirect;
		logic [31:0] redirect_pc;
		logic        ecall;
	} exp_t;

	logic clk, arst_n, in_valid, in_ready, out_valid, out_ready;
	logic [31:0] in_pc, in_rs2_data, in_alu_out, in_br_target, rd_data, redirect_pc;
	logic in_br_flg, in_rf_wen, in_jmp_flg, in_ecall, rd_wen, redirect, ecall;
	mem_op_t     in_mem_op;
	wb_sel_t     in_wb_sel;
	logic [4:0]  in_wb_addr, rd_addr;

	ex_mem_t     drv_arr [128];
	exp_t        exp_arr [128];
	exp_t        exp_head;
	logic [7:0]  ref_mem [1024];
	logic [6:0]  n_b = 7'd0;
	logic [6:0]  drv_idx = 7'd0;
	logic [6:0]  chk_idx = 7'd0;
	logic [31:0] rng = 32'h0e322e4a;
	logic [31:0] cur_pc = 32'h1000;
	int          err_cnt = 0;
	int          timeouts = 0;
	int          cycles = 0;
	int          limit;

	tb_clock u_clk (.clk(clk), .arst_n(arst_n));

	mem_wb_top u_dut (.*);

	function automatic logic [31:0] next_rand(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Little-endian read of the reference memory with RISC-V extension.
	function automatic logic [31:0] load_ref(mem_op_t op, logic [9:0] a);
		logic [7:0] b0, b1;
		b0 = ref_mem[a];
		b1 = ref_mem[a + 10'd1];
		case (op)
			MEN_LB:  return {{24{b0[7]}}, b0};
			MEN_LBU: return {24'd0, b0};
			MEN_LH:  return {{16{b1[7]}}, b1, b0};
			MEN_LHU: return {16'd0, b1, b0};
			default: return {ref_mem[a + 10'd3], ref_mem[a + 10'd2], b1, b0};
		endcase
	endfunction

	task automatic add_bundle(input mem_op_t op, input wb_sel_t sel, input logic [31:0] alu,
			input logic [31:0] rs2, input logic br, input logic jmp, input logic wen,
			input logic ec, input logic [4:0] rd);
		ex_mem_t    b;
		exp_t       e;
		logic [9:0] a;
		a = alu[9:0];
		b = '{pc: cur_pc, rs2_data: rs2, alu_out: alu, br_flg: br, br_target: cur_pc + 32'h100,
			mem_op: op, rf_wen: wen, wb_sel: sel, wb_addr: rd, jmp_flg: jmp, ecall: ec};
		e.rd_wen = wen && (rd != 5'd0);
		e.rd_addr = rd;
		e.rd_data = (sel == WB_PC) ? cur_pc + 32'd4 : (sel == WB_ALU) ? alu :
			(op inside {MEN_LB, MEN_LBU, MEN_LH, MEN_LHU, MEN_LW}) ? load_ref(op, a) : '1;
		e.redirect = br || jmp;
		e.redirect_pc = br ? b.br_target : alu;
		e.ecall = ec;
		if (op inside {MEN_SB, MEN_SH, MEN_SW})
			ref_mem[a] = rs2[7:0];
		if (op inside {MEN_SH, MEN_SW})
			ref_mem[a + 10'd1] = rs2[15:8];
		if (op == MEN_SW) begin
			ref_mem[a + 10'd2] = rs2[23:16];
			ref_mem[a + 10'd3] = rs2[31:24];
		end
		drv_arr[n_b] = b;
		exp_arr[n_b] = e;
		n_b = n_b + 7'd1;
		cur_pc = cur_pc + 32'd4;
	endtask

	task automatic expect_bit(input string name, input logic exp, input logic act);
		assert (act === exp) else begin
			err_cnt++;
			$display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic build_tests();
		logic [31:0] addr;
		add_bundle(MEN_X, WB_ALU, 32'h1234_5678, '0, 0, 0, 1, 0, 5'd5);
		add_bundle(MEN_X, WB_PC, 32'h0bad_f00d, '0, 0, 0, 1, 0, 5'd6);
		add_bundle(MEN_X, WB_ALU, 32'h0000_00aa, '0, 0, 0, 1, 0, 5'd0);
		add_bundle(MEN_X, WB_ALU, 32'h0000_00bb, '0, 0, 0, 0, 0, 5'd9);
		// A bundle without a load reads back all ones.
		add_bundle(MEN_X, WB_MEM, 32'h0000_00cc, '0, 0, 0, 1, 0, 5'd8);
		add_bundle(MEN_SW, WB_ALU, 32'h40, 32'hdead_beef, 0, 0, 0, 0, 5'd0);
		add_bundle(MEN_LW, WB_MEM, 32'h40, '0, 0, 0, 1, 0, 5'd7);
		add_bundle(MEN_SW, WB_ALU, 32'h80, 32'h1122_3344, 0, 0, 0, 0, 5'd0);
		for (int off = 0; off < 4; off++) begin
			add_bundle(MEN_SB, WB_ALU, 32'h80 + off, 32'h5a5a_5a70 + off * 32'h21, 0, 0, 0, 0, 5'd0);
			add_bundle(MEN_LW, WB_MEM, 32'h80, '0, 0, 0, 1, 0, 5'd10);
			add_bundle(MEN_LB, WB_MEM, 32'h80 + off, '0, 0, 0, 1, 0, 5'd11);
			add_bundle(MEN_LBU, WB_MEM, 32'h80 + off, '0, 0, 0, 1, 0, 5'd12);
		end
		add_bundle(MEN_SW, WB_ALU, 32'h90, 32'ha5a5_a5a5, 0, 0, 0, 0, 5'd0);
		for (int off = 0; off < 4; off += 2) begin
			addr = (off == 0) ? 32'h1234_8765 : 32'hcafe_4321;
			add_bundle(MEN_SH, WB_ALU, 32'h90 + off, addr, 0, 0, 0, 0, 5'd0);
			add_bundle(MEN_LW, WB_MEM, 32'h90, '0, 0, 0, 1, 0, 5'd13);
			add_bundle(MEN_LH, WB_MEM, 32'h90 + off, '0, 0, 0, 1, 0, 5'd14);
			add_bundle(MEN_LHU, WB_MEM, 32'h90 + off, '0, 0, 0, 1, 0, 5'd15);
		end
		add_bundle(MEN_X, WB_ALU, 32'h0000_0001, '0, 1, 0, 0, 0, 5'd0);
		add_bundle(MEN_X, WB_PC, 32'h0000_2468, '0, 0, 1, 1, 0, 5'd1);
		add_bundle(MEN_X, WB_ALU, 32'h0000_0073, '0, 0, 0, 0, 1, 5'd0);
		// Random mix over words that hold known data.
		for (int i = 0; i < 12; i++) begin
			rng = next_rand(rng);
			addr = (rng[5:4] == 2'd0) ? 32'h40 : (rng[5:4] == 2'd1) ? 32'h80 : 32'h90;
			case (rng[1:0])
				2'd0: add_bundle(MEN_X, WB_ALU, rng, '0, 0, 0, 1, 0, rng[12:8]);
				2'd1: add_bundle(MEN_SW, WB_ALU, addr, rng, 0, 0, 0, 0, 5'd0);
				2'd2: add_bundle(MEN_LW, WB_MEM, addr, '0, 0, 0, 1, 0, 5'd16);
				default: add_bundle(MEN_LBU, WB_MEM, addr + {30'd0, rng[9:8]}, '0, 0, 0, 1, 0, 5'd17);
			endcase
		end
	endtask

	assign exp_head = exp_arr[chk_idx];

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (arst_n && out_valid && out_ready)
			chk_idx <= chk_idx + 7'd1;
	end

	a_count: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> chk_idx < n_b)
		else begin
			err_cnt++;
			$display("An output came out with no bundle left to match it at %0t", $time);
		end
	a_rd_wen: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> rd_wen === exp_head.rd_wen)
		else begin
			err_cnt++;
			$display("ERR %0t rd_wen expected %b actual %b", $time,
				$sampled(exp_head.rd_wen), $sampled(rd_wen));
		end
	a_rd_addr: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> rd_addr === exp_head.rd_addr)
		else begin
			err_cnt++;
			$display("ERR %0t rd_addr expected %0d actual %0d", $time,
				$sampled(exp_head.rd_addr), $sampled(rd_addr));
		end
	a_rd_data: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> rd_data === exp_head.rd_data)
		else begin
			err_cnt++;
			$display("ERR %0t rd_data expected %h actual %h", $time,
				$sampled(exp_head.rd_data), $sampled(rd_data));
		end
	a_redirect: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> redirect === exp_head.redirect && ecall === exp_head.ecall)
		else begin
			err_cnt++;
			$display("ERR %0t redirect/ecall expected %b/%b actual %b/%b", $time,
				$sampled(exp_head.redirect), $sampled(exp_head.ecall),
				$sampled(redirect), $sampled(ecall));
		end
	a_redirect_pc: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready && exp_head.redirect |-> redirect_pc === exp_head.redirect_pc)
		else begin
			err_cnt++;
			$display("ERR %0t redirect_pc expected %h actual %h", $time,
				$sampled(exp_head.redirect_pc), $sampled(redirect_pc));
		end
	a_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(rd_data) && $stable(rd_wen)
			&& $stable(rd_addr) && $stable(redirect) && $stable(redirect_pc) && $stable(ecall))
		else begin
			err_cnt++;
			$display("Outputs changed under back-pressure at %0t", $time);
		end

	// Driver presents the next bundle until in_ready takes it.
	initial begin
		in_valid = 1'b0;
		out_ready = 1'b0;
		{in_pc, in_rs2_data, in_alu_out, in_br_target} = '0;
		{in_br_flg, in_rf_wen, in_jmp_flg, in_ecall, in_wb_addr} = '0;
		in_mem_op = MEN_X;
		in_wb_sel = WB_ALU;
		wait (arst_n);
		forever begin
			@(posedge clk);
			if (in_valid && in_ready)
				drv_idx = drv_idx + 7'd1;
			#2;
			rng = next_rand(rng);
			out_ready = rng[0];
			in_valid = drv_idx < n_b;
			if (drv_idx < n_b) begin
				in_pc = drv_arr[drv_idx].pc;
				in_rs2_data = drv_arr[drv_idx].rs2_data;
				in_alu_out = drv_arr[drv_idx].alu_out;
				in_br_target = drv_arr[drv_idx].br_target;
				in_br_flg = drv_arr[drv_idx].br_flg;
				in_rf_wen = drv_arr[drv_idx].rf_wen;
				in_jmp_flg = drv_arr[drv_idx].jmp_flg;
				in_ecall = drv_arr[drv_idx].ecall;
				in_mem_op = drv_arr[drv_idx].mem_op;
				in_wb_sel = drv_arr[drv_idx].wb_sel;
				in_wb_addr = drv_arr[drv_idx].wb_addr;
			end
		end
	end

	initial begin
		build_tests();
		limit = 40 * int'(n_b) + 100;
		wait (arst_n);
		@(negedge clk);
		expect_bit("out_valid", 1'b0, out_valid);
		expect_bit("redirect", 1'b0, redirect);
		expect_bit("in_ready", 1'b1, in_ready);
		while (chk_idx < n_b && cycles < limit)
			@(posedge clk);
		if (chk_idx < n_b) begin
			timeouts++;
			$display("Timed out with %0d of %0d bundles out", chk_idx, n_b);
		end
		repeat (2) @(posedge clk);
		$display("Errors: %0d, timeouts: %0d", err_cnt, timeouts);
		if (err_cnt == 0 && timeouts == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit (
	input  logic                   clk,
	input  logic                   arst_n,
	stage_if.sink                  up,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic                   rd_wen,
	output logic [4:0]             rd_addr,
	output logic [core_pkg::xlen-1:0] rd_data,
	output logic                   redirect,
	output logic [core_pkg::xlen-1:0] redirect_pc,
	output logic                   ecall
);

	import core_pkg::*;

	mem_wb_t         b;
	logic            accept;
	logic [xlen-1:0] sel_data;

	assign b = up.payload;
	assign up.ready = !out_valid || out_ready;
	assign accept = up.valid && up.ready;

	always_comb begin
		case (b.wb_sel)
			WB_MEM:  sel_data = b.read_data;
			WB_PC:   sel_data = b.pc + 32'd4;
			default: sel_data = b.alu_out;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			rd_wen <= 1'b0;
			redirect <= 1'b0;
			ecall <= 1'b0;
		end else if (accept) begin
			out_valid <= 1'b1;
			// x0 is never written.
			rd_wen <= b.rf_wen && (b.wb_addr != 5'd0);
			redirect <= b.br_flg || b.jmp_flg;
			ecall <= b.ecall;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rd_addr <= b.wb_addr;
			rd_data <= sel_data;
			redirect_pc <= b.br_flg ? b.br_target : b.alu_out;
		end
	end

endmodule
